// File: design/plic_pkg.sv
package plic_pkg;

    localparam int num_sources = 16;
    localparam int id_w        = 4;
    localparam int addr_w      = 12;
    localparam int data_w      = 32;

    // address map
    localparam logic [addr_w-1:0] addr_int_en   = 12'h000;
    localparam logic [addr_w-1:0] addr_pri_base = 12'h010;  // one byte per source
    localparam logic [addr_w-1:0] addr_irq_id   = 12'h020;
    localparam logic [addr_w-1:0] addr_mvec     = 12'h024;
    localparam logic [addr_w-1:0] addr_marg     = 12'h028;
    localparam logic [addr_w-1:0] addr_vec_base = 12'h100;  // one word per source
    localparam logic [addr_w-1:0] addr_obj_base = 12'h200;

    typedef enum logic [2:0] {
        region_none,
        region_en,
        region_pri,
        region_irq_id,
        region_mvec,
        region_marg,
        region_vec,
        region_obj
    } reg_region_e;

    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [3:0]        strb;
    } plic_wr_t;

    typedef logic [num_sources-1:0][7:0]        pri_vec_t;
    typedef logic [num_sources-1:0][data_w-1:0] word_tab_t;

    typedef struct packed {
        logic [num_sources-1:0] int_en;
        pri_vec_t               pri;
    } plic_cfg_t;

    typedef struct packed {
        logic            valid;
        logic [id_w-1:0] id;
    } plic_sel_t;

endpackage

// File: design/plic_priority_arbiter.sv
module plic_priority_arbiter
    import plic_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [num_sources-1:0] irq_sources,
    input  plic_cfg_t              cfg,
    output plic_sel_t              sel
);

    // one candidate in the compare tree
    typedef struct packed {
        logic            valid;
        logic [7:0]      pri;
        logic [id_w-1:0] id;
    } node_t;

    logic [num_sources-1:0] masked_r;

    node_t lvl0 [num_sources];
    node_t lvl1 [8];
    node_t lvl2 [4];
    node_t lvl3 [2];
    node_t root;

    // a is always the lower id, so it wins ties
    // two invalid inputs also give a, leaving id 0 when nothing is pending
    function automatic node_t pick(input node_t a, input node_t b);
        if (!b.valid || (a.valid && a.pri >= b.pri)) begin
            return a;
        end
        return b;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            masked_r <= '0;
        end else begin
            masked_r <= irq_sources & cfg.int_en;
        end
    end

    always_comb begin
        for (int i = 0; i < num_sources; i++) begin
            lvl0[i] = '{valid: masked_r[i], pri: cfg.pri[i], id: id_w'(i)};
        end
        for (int i = 0; i < 8; i++) begin
            lvl1[i] = pick(lvl0[2*i], lvl0[2*i+1]);
        end
        for (int i = 0; i < 4; i++) begin
            lvl2[i] = pick(lvl1[2*i], lvl1[2*i+1]);
        end
        for (int i = 0; i < 2; i++) begin
            lvl3[i] = pick(lvl2[2*i], lvl2[2*i+1]);
        end
        root = pick(lvl3[0], lvl3[1]);
    end

    // valid propagates up from any masked bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= '0;
        end else begin
            sel.valid <= root.valid;
            sel.id    <= root.id;
        end
    end

endmodule

// File: design/plic_regfile.sv
module plic_regfile
    import plic_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  plic_wr_t          bus_wr,
    input  logic [addr_w-1:0] raddr,
    output logic [data_w-1:0] rdata,
    input  logic [id_w-1:0]   irq_id,
    input  logic [data_w-1:0] mvec,
    input  logic [data_w-1:0] marg,
    output plic_cfg_t         cfg,
    output word_tab_t         vec_tab,
    output word_tab_t         obj_tab
);

    logic [num_sources-1:0] int_en;
    pri_vec_t               pri;
    word_tab_t              vec;
    word_tab_t              obj;

    reg_region_e     wr_region;
    reg_region_e     rd_region;
    logic [id_w-1:0] wr_idx;
    logic [id_w-1:0] rd_idx;

    function automatic reg_region_e decode(input logic [addr_w-1:0] addr);
        reg_region_e region;
        region = region_none;
        if (addr == addr_int_en) begin
            region = region_en;
        end else if (addr[addr_w-1:id_w] == addr_pri_base[addr_w-1:id_w]) begin
            region = region_pri;  // 16 bytes, so every lane maps to a source
        end else if (addr == addr_irq_id) begin
            region = region_irq_id;
        end else if (addr == addr_mvec) begin
            region = region_mvec;
        end else if (addr == addr_marg) begin
            region = region_marg;
        end else if (addr[addr_w-1:id_w+2] == addr_vec_base[addr_w-1:id_w+2]) begin
            region = region_vec;
        end else if (addr[addr_w-1:id_w+2] == addr_obj_base[addr_w-1:id_w+2]) begin
            region = region_obj;
        end
        return region;
    endfunction

    assign wr_region = decode(bus_wr.addr);
    assign rd_region = decode(raddr);
    assign wr_idx    = bus_wr.addr[id_w+1:2];  // word index into the tables
    assign rd_idx    = raddr[id_w+1:2];

    // live tables, written directly from the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_en <= '0;
            pri    <= '0;
            vec    <= '0;
            obj    <= '0;
        end else if (bus_wr.en) begin
            case (wr_region)
                region_en: begin
                    if (bus_wr.strb[0]) begin
                        int_en[7:0] <= bus_wr.data[7:0];
                    end
                    if (bus_wr.strb[1]) begin
                        int_en[15:8] <= bus_wr.data[15:8];
                    end
                end
                region_pri: begin
                    for (int b = 0; b < 4; b++) begin
                        if (bus_wr.strb[b]) begin
                            pri[{bus_wr.addr[id_w-1:2], 2'(b)}] <= bus_wr.data[b*8 +: 8];
                        end
                    end
                end
                region_vec: vec[wr_idx] <= bus_wr.data;  // full word, strb ignored
                region_obj: obj[wr_idx] <= bus_wr.data;
                default: ;  // read-only or unmapped
            endcase
        end
    end

    // shadow copies one cycle behind, feed arbiter and lookup
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg     <= '0;
            vec_tab <= '0;
            obj_tab <= '0;
        end else begin
            cfg.int_en <= int_en;
            cfg.pri    <= pri;
            vec_tab    <= vec;
            obj_tab    <= obj;
        end
    end

    always_comb begin
        rdata = '0;
        case (rd_region)
            region_en: rdata[num_sources-1:0] = int_en;
            region_pri: begin
                for (int b = 0; b < 4; b++) begin
                    rdata[b*8 +: 8] = pri[{raddr[id_w-1:2], 2'(b)}];
                end
            end
            region_irq_id: rdata[id_w-1:0] = irq_id;
            region_mvec:   rdata = mvec;
            region_marg:   rdata = marg;
            region_vec:    rdata = vec[rd_idx];
            region_obj:    rdata = obj[rd_idx];
            default:       rdata = '0;
        endcase
    end

endmodule

// File: design/plic_top.sv
module plic_top
    import plic_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  plic_wr_t               bus_wr,
    input  logic [addr_w-1:0]      raddr,
    output logic [data_w-1:0]      rdata,
    input  logic [num_sources-1:0] irq_sources,
    output logic                   irq_valid,
    output logic [id_w-1:0]        irq_id
);

    plic_cfg_t         cfg;
    word_tab_t         vec_tab;
    word_tab_t         obj_tab;
    plic_sel_t         sel;
    logic [data_w-1:0] mvec;
    logic [data_w-1:0] marg;

    // decode and storage
    plic_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_wr  (bus_wr),
        .raddr   (raddr),
        .rdata   (rdata),
        .irq_id  (irq_id),
        .mvec    (mvec),
        .marg    (marg),
        .cfg     (cfg),
        .vec_tab (vec_tab),
        .obj_tab (obj_tab)
    );

    plic_priority_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_sources (irq_sources),
        .cfg         (cfg),
        .sel         (sel)
    );

    // result regs, also read back through the regfile
    plic_vector_select u_vector_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .vec_tab   (vec_tab),
        .obj_tab   (obj_tab),
        .irq_valid (irq_valid),
        .irq_id    (irq_id),
        .mvec      (mvec),
        .marg      (marg)
    );

endmodule

// File: design/plic_vector_select.sv
module plic_vector_select
    import plic_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  plic_sel_t         sel,
    input  word_tab_t         vec_tab,
    input  word_tab_t         obj_tab,
    output logic              irq_valid,
    output logic [id_w-1:0]   irq_id,
    output logic [data_w-1:0] mvec,
    output logic [data_w-1:0] marg
);

    logic [data_w-1:0] mvec_stage;
    logic [data_w-1:0] marg_stage;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_valid  <= 1'b0;
            irq_id     <= '0;
            mvec_stage <= '0;
            marg_stage <= '0;
            mvec       <= '0;
            marg       <= '0;
        end else begin
            irq_valid <= sel.valid;
            irq_id    <= sel.id;
            // hold last winner's entries when nothing is pending
            if (sel.valid) begin
                mvec_stage <= vec_tab[sel.id];
                marg_stage <= obj_tab[sel.id];
            end
            mvec <= mvec_stage;  // extra stage for the table mux
            marg <= marg_stage;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the PLIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f verilog.f --top-module plic_tb -o Vplic_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vplic_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: verification/plic_golden.txt
# W addr data strb | R addr rdata
# S sources irq_valid irq_id mvec marg
R 000 00000000
R 010 00000000
R 020 00000000
R 104 00000000
R 214 00000000
S 0000 0 0 00000000 00000000
W 000 0000A5C3 1
W 000 5A5AFF00 2
R 000 0000FFC3
W 010 04030201 f
W 014 AABBCCDD 5
W 01C 04000000 8
W 020 0000000F f
W 040 DEADBEEF f
R 010 04030201
R 014 00BB00DD
R 01C 04000000
R 020 00000000
R 040 00000000
W 10C 8000000C 0
W 114 80000014 0
W 118 80000018 f
W 13C 8000003C 3
W 20C A000000C f
W 214 A0000014 f
W 218 A0000018 1
W 23C A000003C f
R 118 80000018
R 23C A000003C
S 8049 1 6 80000018 A0000018
W 000 0000FFFF 3
S 8008 1 3 8000000C A000000C
S 2020 1 5 80000014 A0000014
W 000 0000FFB7 3
S 8049 1 f 8000003C A000003C
S 0048 0 0 8000003C A000003C
W 000 000000F7 1
S 8049 1 6 80000018 A0000018
W 01C FF000000 8
S 8049 1 f 8000003C A000003C
R 020 0000000F

// File: verification/plic_tb.sv
module plic_tb
    import plic_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period      = 40;
    localparam int settle_cycles   = 8;   // sources to mvec/marg is 4 edges
    localparam int cycles_per_line = 20;
    localparam int timeout_margin  = 100;

    typedef enum logic [1:0] {op_write, op_read, op_sources} op_e;

    typedef struct packed {
        op_e                    op;
        logic [addr_w-1:0]      addr;
        logic [data_w-1:0]      data;  // write data or expected rdata
        logic [3:0]             strb;
        logic [num_sources-1:0] sources;
        logic                   exp_valid;
        logic [id_w-1:0]        exp_id;
        logic [data_w-1:0]      exp_mvec;
        logic [data_w-1:0]      exp_marg;
    } golden_op_t;

    logic                   clk;
    logic                   rst_n;
    plic_wr_t               bus_wr;
    logic [addr_w-1:0]      raddr;
    logic [data_w-1:0]      rdata;
    logic [num_sources-1:0] irq_sources;
    logic                   irq_valid;
    logic [id_w-1:0]        irq_id;

    golden_op_t ops[$];
    int cycle_count = 0;
    int cycle_limit = 0;

    plic_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_wr      (bus_wr),
        .raddr       (raddr),
        .rdata       (rdata),
        .irq_sources (irq_sources),
        .irq_valid   (irq_valid),
        .irq_id      (irq_id)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s expected %h got %h", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_golden();
        int fd;
        int n;
        logic [7:0] tok;
        logic [8*80-1:0] rest;
        logic [31:0] f0, f1, f2, f3, f4;
        golden_op_t g;
        fd = $fopen("verification/plic_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/plic_golden.txt");
        end
        n = $fscanf(fd, " %s", tok);
        while (n == 1) begin
            g = '0;
            if (tok == "#") begin
                n = $fgets(rest, fd);  // skip column notes
            end else if (tok == "W") begin
                if ($fscanf(fd, "%h %h %h", f0, f1, f2) != 3) begin
                    abort_run("golden file has a malformed write line");
                end
                g.op   = op_write;
                g.addr = f0[addr_w-1:0];
                g.data = f1;
                g.strb = f2[3:0];
                ops.push_back(g);
            end else if (tok == "R") begin
                if ($fscanf(fd, "%h %h", f0, f1) != 2) begin
                    abort_run("golden file has a malformed read line");
                end
                g.op   = op_read;
                g.addr = f0[addr_w-1:0];
                g.data = f1;
                ops.push_back(g);
            end else if (tok == "S") begin
                if ($fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4) != 5) begin
                    abort_run("golden file has a malformed sources line");
                end
                g.op        = op_sources;
                g.sources   = f0[num_sources-1:0];
                g.exp_valid = f1[0];
                g.exp_id    = f2[id_w-1:0];
                g.exp_mvec  = f3;
                g.exp_marg  = f4;
                ops.push_back(g);
            end else begin
                abort_run("golden file has an unknown opcode");
            end
            n = $fscanf(fd, " %s", tok);
        end
        $fclose(fd);
    endtask

    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                             input logic [3:0] strb);
        @(negedge clk);
        bus_wr = '{en: 1'b1, addr: addr, data: data, strb: strb};
        @(negedge clk);
        bus_wr.en = 1'b0;
    endtask

    task automatic read_check(input logic [addr_w-1:0] addr, input logic [data_w-1:0] expected,
                              input string name);
        @(negedge clk);
        raddr = addr;
        #1;  // rdata is combinational
        check_value(name, rdata, expected);
    endtask

    task automatic sources_check(input golden_op_t g);
        @(negedge clk);
        irq_sources = g.sources;
        repeat (settle_cycles) @(negedge clk);
        check_value("irq_valid", 32'(irq_valid), 32'(g.exp_valid));
        check_value("irq_id", 32'(irq_id), 32'(g.exp_id));
        read_check(addr_mvec, g.exp_mvec, "mvec");
        read_check(addr_marg, g.exp_marg, "marg");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        bus_wr      = '0;
        raddr       = '0;
        irq_sources = '0;
        load_golden();
        cycle_limit = cycles_per_line * ops.size() + timeout_margin;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (ops[i]) begin
            case (ops[i].op)
                op_write:   write_reg(ops[i].addr, ops[i].data, ops[i].strb);
                op_read:    read_check(ops[i].addr, ops[i].data,
                                       $sformatf("rdata@%h", ops[i].addr));
                op_sources: sources_check(ops[i]);
                default:    abort_run("unknown operation in golden list");
            endcase
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: verilog.f
design/plic_pkg.sv
design/plic_regfile.sv
design/plic_priority_arbiter.sv
design/plic_vector_select.sv
design/plic_top.sv
verification/plic_tb.sv
